// File: filelist.f
+incdir+hdl
hdl/mem_stage_pkg.sv
hdl/mem_store_align.sv
hdl/dmem_sram.sv
hdl/mem_result_stage.sv
hdl/mem_stage_top.sv
dv/tb_clkgen.sv
dv/mem_stage_assertions.sv
dv/tb_mem_stage.sv

// File: Bender.yml
package:
  name: mem_stage

export_include_dirs:
  - hdl

sources:
  - files:
      - hdl/mem_stage_pkg.sv
      - hdl/mem_store_align.sv
      - hdl/dmem_sram.sv
      - hdl/mem_result_stage.sv
      - hdl/mem_stage_top.sv
  - target: any(simulation, test)
    files:
      - dv/tb_clkgen.sv
      - dv/mem_stage_assertions.sv
      - dv/tb_mem_stage.sv

// File: dv/tb_mem_stage.sv
`timescale 1ns/1ps
`include "mem_stage_config.svh"

module tb_mem_stage;

    import mem_stage_pkg::*;

    localparam int                      NUM_OPS      = 600;
    localparam int                      RESET_CYCLES = 16;
    localparam int                      WIN_WORDS    = 64;       // Small window forces reuse
    localparam logic [`MEM_DMEM_AW-1:0] WIN_BASE     = 'h1C0;
    localparam logic [31:0]             SEED         = 32'd92004;
    localparam real                     TIMEOUT_NS   =
        (NUM_OPS + WIN_WORDS + 4) * 40.0 + RESET_CYCLES * 40.0 + 2000.0;

    logic                 clk;
    logic                 resetn;
    ex_mem_t              ex;
    mem_wb_t              wb;
    logic [`MEM_XLEN-1:0] fwd;
    logic [31:0]          lfsr;
    logic [`MEM_XLEN-1:0] shadow [`MEM_DMEM_DEPTH];  // Reference memory
    mem_wb_t              exp_q [$];                  // Op in flight, at most one
    logic [`MEM_XLEN-1:0] exp_fwd;

    tb_clkgen u_clkgen (.clk_o(clk));

    mem_stage_top uut (.clk(clk), .resetn(resetn), .ex_i(ex), .wb_o(wb), .fwd_o(fwd));

    // ******************************
    // Random source
    // ******************************
    // Galois form of x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_step(lfsr);  // One step per bit
            v    = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    // ******************************
    // Reference model
    // ******************************
    function automatic logic is_load_op(input mem_op_e op);
        return op inside {OP_LB, OP_LH, OP_LW, OP_LBU, OP_LHU};
    endfunction

    function automatic logic [31:0] extend_load(input mem_op_e op, input logic [31:0] word,
                                                input logic [1:0] off);
        logic signed [31:0] t;
        case (op)
            OP_LB: begin
                t = word << (24 - 8 * off);  // Lane to the top, then arithmetic shift
                return t >>> 24;
            end
            OP_LH: begin
                t = word << (off[1] ? 0 : 16);
                return t >>> 16;
            end
            OP_LBU:  return (word >> (8 * off)) & 32'h0000_00FF;
            OP_LHU:  return (word >> (off[1] ? 16 : 0)) & 32'h0000_FFFF;
            OP_LW:   return word;
            default: return '0;
        endcase
    endfunction

    function automatic logic [31:0] pick_source(input result_src_t src,
                                                input logic [31:0] alu, input logic [31:0] imm,
                                                input logic [31:0] load, input logic [31:0] pc4);
        logic [31:0] r;
        r = '0;
        if (src[SRC_ALU])
            r |= alu;
        if (src[SRC_IMM])
            r |= imm;
        if (src[SRC_LOAD])
            r |= load;
        if (src[SRC_PC4])
            r |= pc4;
        return r;
    endfunction

    task automatic shadow_store(input ex_mem_t op);
        logic [`MEM_DMEM_AW-1:0] a;
        logic [1:0]              off;
        a   = op.alu_result[`MEM_DMEM_AW+1:2];
        off = op.alu_result[1:0];
        case (op.mem_op)
            OP_SB:   shadow[a][8*off +: 8] = op.store_data[7:0];
            OP_SH:   shadow[a][16*off[1] +: 16] = op.store_data[15:0];  // Bit 0 ignored
            OP_SW:   shadow[a] = op.store_data;
            default: ;
        endcase
    endtask

    // ******************************
    // Stimulus
    // ******************************
    // Fill mode writes an address-derived word with SW
    function automatic ex_mem_t random_op(input logic fill, input logic [5:0] fill_idx);
        ex_mem_t                 op;
        logic [`MEM_DMEM_AW-1:0] a;
        logic [2:0]              k;
        op            = '0;
        op.valid      = 1'b1;
        op.mem_op     = fill ? OP_SW : mem_op_e'(4'(rand_bits(4) % 9));
        a             = WIN_BASE + (fill ? fill_idx : 6'(rand_bits(6)));
        op.alu_result = rand_bits(32);
        op.alu_result[`MEM_DMEM_AW+1:2] = a;
        op.store_data = fill ? {6'h2A, a, 6'h15, ~a} : rand_bits(32);
        op.ext_imm    = rand_bits(32);
        op.pc_plus    = rand_bits(32);
        op.reg_we     = 1'(rand_bits(1));
        op.rd         = 5'(rand_bits(5));
        k             = 3'(rand_bits(3));
        op.result_src = (k == 3'd7) ? 4'b0000 : (4'b0001 << k[1:0]);
        if (is_load_op(op.mem_op) && rand_bits(1) == 32'd1)
            op.result_src = 4'b0100;  // Bias loads toward load data
        return op;
    endfunction

    // Invalid SW with live address and data, must not write
    function automatic ex_mem_t bubble_op();
        ex_mem_t op;
        op            = '0;
        op.mem_op     = OP_SW;
        op.alu_result = rand_bits(32);
        op.alu_result[`MEM_DMEM_AW+1:2] = WIN_BASE + 6'(rand_bits(6));
        op.store_data = rand_bits(32);
        return op;
    endfunction

    // ******************************
    // Checking
    // ******************************
    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("Fail %s: actual %h, expected %h at %0t", name, actual, expected, $time);
            $display("sim failed");
            $fatal(1, "Mismatch on %s", name);
        end
    endtask

    task automatic check_outputs();
        mem_wb_t e;
        if (uut.u_assert.err_count != 0) begin
            $display("A concurrent assertion failed in the last cycle");
            $display("sim failed");
            $fatal(1, "Assertion failure");
        end
        if (exp_q.size() > 0) begin
            e = exp_q.pop_front();
            check_value("wb_o.valid", 32'(wb.valid), 32'(e.valid));
            check_value("wb_o.reg_we", 32'(wb.reg_we), 32'(e.reg_we));
            check_value("wb_o.rd", 32'(wb.rd), 32'(e.rd));
            check_value("wb_o.result", wb.result, e.result);
            check_value("fwd_o", fwd, exp_fwd);
        end
    endtask

    // Check last cycle at the falling edge, then drive and predict
    task automatic issue_op(input ex_mem_t op);
        mem_wb_t              e;
        logic [`MEM_XLEN-1:0] load_term;
        @(negedge clk);
        check_outputs();
        ex        = op;
        load_term = is_load_op(op.mem_op)
                  ? extend_load(op.mem_op, shadow[op.alu_result[`MEM_DMEM_AW+1:2]],
                                op.alu_result[1:0])
                  : '0;
        e.valid   = op.valid;
        e.reg_we  = op.reg_we;
        e.rd      = op.rd;
        e.result  = pick_source(op.result_src, op.alu_result, op.ext_imm, load_term, op.pc_plus);
        exp_q.push_back(e);
        exp_fwd   = pick_source(op.result_src, op.alu_result, op.ext_imm, '0, op.pc_plus);
        if (op.valid)
            shadow_store(op);  // After the read, so the load sees old data
    endtask

    // ******************************
    // Main sequence and watchdog
    // ******************************
    initial begin
        resetn  = 1'b0;
        ex      = '0;
        lfsr    = SEED;
        exp_fwd = '0;
        repeat (RESET_CYCLES) begin
            @(negedge clk);
            check_value("wb_o.valid", 32'(wb.valid), 32'd0);
            check_value("wb_o.reg_we", 32'(wb.reg_we), 32'd0);
            check_value("wb_o.result", wb.result, 32'd0);
        end
        resetn = 1'b1;
        exp_q.push_back('0);  // First cycle after reset sees idle input
        for (int i = 0; i < WIN_WORDS; i++)
            issue_op(random_op(1'b1, 6'(i)));
        for (int n = 0; n < NUM_OPS; n++) begin
            if (rand_bits(3) == 32'd0)
                issue_op(bubble_op());
            else
                issue_op(random_op(1'b0, 6'd0));
        end
        @(negedge clk);
        check_outputs();  // Drain the last op
        if (uut.u_assert.err_count != 0) begin
            $display("Concurrent assertions failed %0d times", uut.u_assert.err_count);
            $display("sim failed");
            $fatal(1, "Assertion failures");
        end else begin
            $display("sim passed");
            $finish;
        end
    end

    initial begin
        #(TIMEOUT_NS);
        $display("Timeout, the run did not finish in the expected time");
        $display("sim failed");
        $fatal(1, "Watchdog expired");
    end

endmodule

// File: dv/mem_stage_assertions.sv
`timescale 1ns/1ps

module mem_stage_assertions (
    input logic                     clk,
    input logic                     resetn,
    input mem_stage_pkg::ex_mem_t   ex_i,
    input mem_stage_pkg::dmem_req_t req_i,
    input mem_stage_pkg::mem_wb_t   wb_i
);

    import mem_stage_pkg::*;

    int unsigned err_count = 0;  // Failure count, polled every cycle

    // ******************************
    // Request and write-back rules
    // ******************************
    ce_off_in_bubble: assert property (@(posedge clk) disable iff (!resetn)
        !ex_i.valid |-> !req_i.ce)
        else begin
            err_count++;
            $error("RAM chip enable high while input valid is low");
        end

    // Writes come from store ops only
    we_only_for_store: assert property (@(posedge clk) disable iff (!resetn)
        req_i.we |-> (ex_i.mem_op inside {OP_SB, OP_SH, OP_SW}))
        else begin
            err_count++;
            $error("RAM write enable high without a store operation");
        end

    no_wb_after_bubble: assert property (@(posedge clk) disable iff (!resetn)
        !ex_i.valid |=> !wb_i.valid)  // Bubble gives idle write-back
        else begin
            err_count++;
            $error("Write-back valid high in the cycle after a bubble");
        end

endmodule

bind mem_stage_top mem_stage_assertions u_assert (
    .clk    (clk),
    .resetn (resetn),
    .ex_i   (ex_i),
    .req_i  (req),
    .wb_i   (wb_o)
);

// File: dv/tb_clkgen.sv
`timescale 1ns/1ps

module tb_clkgen (
    output logic clk_o
);

    // 40 ns period, starts low
    initial begin
        clk_o = 1'b0;
        forever #20 clk_o = ~clk_o;
    end

endmodule

// File: hdl/mem_stage_top.sv
`timescale 1ns/1ps
`include "mem_stage_config.svh"

module mem_stage_top (
    input  logic                   clk,
    input  logic                   resetn,
    input  mem_stage_pkg::ex_mem_t ex_i,
    output mem_stage_pkg::mem_wb_t wb_o,
    output logic [`MEM_XLEN-1:0]   fwd_o
);

    import mem_stage_pkg::*;

    dmem_req_t            req;    // Store align to RAM
    logic [`MEM_XLEN-1:0] rdata;  // RAM word, one cycle late

    // ******************************
    // Input side
    // ******************************
    mem_store_align u_store_align (
        .ex_i  (ex_i),
        .req_o (req)
    );

    // ******************************
    // Data memory
    // ******************************
    dmem_sram u_dmem (
        .clk     (clk),
        .req_i   (req),
        .rdata_o (rdata)
    );

    // ******************************
    // Output side
    // ******************************
    // Register, load extension, result select and forwarding
    mem_result_stage u_result (
        .clk     (clk),
        .resetn  (resetn),
        .ex_i    (ex_i),
        .rdata_i (rdata),
        .wb_o    (wb_o),
        .fwd_o   (fwd_o)
    );

endmodule

// File: hdl/mem_result_stage.sv
`timescale 1ns/1ps
`include "mem_stage_config.svh"

module mem_result_stage (
    input  logic                   clk,
    input  logic                   resetn,
    input  mem_stage_pkg::ex_mem_t ex_i,
    input  logic [`MEM_XLEN-1:0]   rdata_i,
    output mem_stage_pkg::mem_wb_t wb_o,
    output logic [`MEM_XLEN-1:0]   fwd_o
);

    import mem_stage_pkg::*;

    // Write-back register
    logic                 valid_q;
    logic                 reg_we_q;
    logic [4:0]           rd_q;
    result_src_t          src_q;
    logic [`MEM_XLEN-1:0] alu_q;
    logic [`MEM_XLEN-1:0] imm_q;
    logic [`MEM_XLEN-1:0] pc4_q;
    load_ctx_t            ctx_q;     // Load op and byte offset

    logic [7:0]           lane_b;    // Addressed byte
    logic [15:0]          lane_h;    // Addressed half
    logic [`MEM_XLEN-1:0] load_data;

    // ******************************
    // Pipeline register
    // ******************************
    always_ff @(posedge clk) begin
        if (!resetn) begin
            valid_q  <= 1'b0;
            reg_we_q <= 1'b0;
            src_q    <= '0;   // Zero result out of reset
        end else begin
            valid_q  <= ex_i.valid;
            reg_we_q <= ex_i.reg_we;
            src_q    <= ex_i.result_src;
        end
    end

    always_ff @(posedge clk) begin
        rd_q           <= ex_i.rd;
        alu_q          <= ex_i.alu_result;
        imm_q          <= ex_i.ext_imm;
        pc4_q          <= ex_i.pc_plus;
        ctx_q.mem_op   <= ex_i.mem_op;
        ctx_q.byte_off <= ex_i.alu_result[1:0];
    end

    // ******************************
    // Load extension
    // ******************************
    assign lane_b = rdata_i[{ctx_q.byte_off, 3'b000} +: 8];
    assign lane_h = ctx_q.byte_off[1] ? rdata_i[31:16] : rdata_i[15:0];  // Bit 0 ignored

    always_comb begin
        case (ctx_q.mem_op)
            OP_LB:   load_data = {{(`MEM_XLEN-8){lane_b[7]}}, lane_b};
            OP_LH:   load_data = {{(`MEM_XLEN-16){lane_h[15]}}, lane_h};
            OP_LW:   load_data = rdata_i;
            OP_LBU:  load_data = {{(`MEM_XLEN-8){1'b0}}, lane_b};
            OP_LHU:  load_data = {{(`MEM_XLEN-16){1'b0}}, lane_h};
            default: load_data = '0;          // Not a load, nothing read
        endcase
    end

    // ******************************
    // Result and forwarding select
    // ******************************
    always_comb begin
        wb_o.valid  = valid_q;
        wb_o.reg_we = reg_we_q;
        wb_o.rd     = rd_q;
        wb_o.result = ({`MEM_XLEN{src_q[SRC_ALU]}}  & alu_q)
                    | ({`MEM_XLEN{src_q[SRC_IMM]}}  & imm_q)
                    | ({`MEM_XLEN{src_q[SRC_LOAD]}} & load_data)
                    | ({`MEM_XLEN{src_q[SRC_PC4]}}  & pc4_q);
    end

    // Same cycle as ex_i, load data still in the RAM so that term is zero
    assign fwd_o = ({`MEM_XLEN{ex_i.result_src[SRC_ALU]}} & ex_i.alu_result)
                 | ({`MEM_XLEN{ex_i.result_src[SRC_IMM]}} & ex_i.ext_imm)
                 | ({`MEM_XLEN{ex_i.result_src[SRC_PC4]}} & ex_i.pc_plus);

endmodule

// File: hdl/dmem_sram.sv
`timescale 1ns/1ps
`include "mem_stage_config.svh"

module dmem_sram (
    input  logic                     clk,
    input  mem_stage_pkg::dmem_req_t req_i,
    output logic [`MEM_XLEN-1:0]     rdata_o
);

    // ******************************
    // Storage
    // ******************************
    logic [`MEM_XLEN-1:0] mem [`MEM_DMEM_DEPTH];  // Contents undefined at power-up

    // Byte-masked write port
    always_ff @(posedge clk) begin
        if (req_i.ce && req_i.we) begin
            for (int b = 0; b < 4; b++) begin
                if (req_i.be[b]) begin
                    mem[req_i.addr][8*b +: 8] <= req_i.wdata[8*b +: 8];
                end
            end
        end
    end

    // ******************************
    // Read port
    // ******************************
    // One cycle latency, output holds between reads
    always_ff @(posedge clk) begin
        if (req_i.ce && !req_i.we) begin
            rdata_o <= mem[req_i.addr];  // Old data if written later
        end
    end

endmodule

// File: hdl/mem_store_align.sv
`timescale 1ns/1ps
`include "mem_stage_config.svh"

module mem_store_align (
    input  mem_stage_pkg::ex_mem_t   ex_i,
    output mem_stage_pkg::dmem_req_t req_o
);

    import mem_stage_pkg::*;

    logic       is_load;
    logic       is_store;
    logic [1:0] byte_off;  // Low address bits pick the lane

    // ******************************
    // Operation decode
    // ******************************
    assign is_load  = ex_i.valid && (ex_i.mem_op inside {OP_LB, OP_LH, OP_LW, OP_LBU, OP_LHU});
    assign is_store = ex_i.valid && (ex_i.mem_op inside {OP_SB, OP_SH, OP_SW});
    assign byte_off = ex_i.alu_result[1:0];

    // ******************************
    // Request build
    // ******************************
    always_comb begin
        req_o.ce    = is_load | is_store;                     // Bubbles leave the RAM idle
        req_o.we    = is_store;
        req_o.addr  = ex_i.alu_result[`MEM_DMEM_AW+1:2];      // Word address
        req_o.be    = 4'b0000;
        req_o.wdata = '0;

        if (is_store) begin
            case (ex_i.mem_op)
                OP_SB: begin
                    // Byte copied to every lane, enable picks one
                    req_o.wdata = {4{ex_i.store_data[7:0]}};
                    req_o.be    = 4'b0001 << byte_off;
                end
                OP_SH: begin
                    req_o.wdata = {2{ex_i.store_data[15:0]}};
                    // Bit 0 ignored, no misalign trap
                    req_o.be    = byte_off[1] ? 4'b1100 : 4'b0011;
                end
                OP_SW: begin
                    req_o.wdata = ex_i.store_data;
                    req_o.be    = 4'b1111;
                end
                default: begin
                    req_o.wdata = '0;
                    req_o.be    = 4'b0000;
                end
            endcase
        end
    end

endmodule

// File: hdl/mem_stage_pkg.sv
`include "mem_stage_config.svh"

package mem_stage_pkg;

    // ******************************
    // Operation and source codes
    // ******************************

    typedef enum logic [3:0] {
        OP_NONE = 4'd0,  // No memory access
        OP_LB   = 4'd1,  // Signed byte load
        OP_LH   = 4'd2,  // Signed half load
        OP_LW   = 4'd3,
        OP_LBU  = 4'd4,  // Unsigned byte load
        OP_LHU  = 4'd5,  // Unsigned half load
        OP_SB   = 4'd6,
        OP_SH   = 4'd7,
        OP_SW   = 4'd8
    } mem_op_e;

    // One-hot write-back source, all zero gives a zero result
    typedef logic [3:0] result_src_t;

    localparam int unsigned SRC_ALU  = 0;  // ALU result
    localparam int unsigned SRC_IMM  = 1;  // Extended immediate
    localparam int unsigned SRC_LOAD = 2;  // Extended load data
    localparam int unsigned SRC_PC4  = 3;  // PC plus 4

    // ******************************
    // Stage bundles
    // ******************************

    typedef struct packed {
        logic                 valid;
        mem_op_e              mem_op;
        logic [`MEM_XLEN-1:0] alu_result;  // Also the byte address
        logic [`MEM_XLEN-1:0] store_data;
        logic [`MEM_XLEN-1:0] ext_imm;
        logic [`MEM_XLEN-1:0] pc_plus;
        logic                 reg_we;
        logic [4:0]           rd;
        result_src_t          result_src;
    } ex_mem_t;

    typedef struct packed {
        logic                    ce;     // Chip enable, active high
        logic                    we;     // High for stores
        logic [`MEM_DMEM_AW-1:0] addr;   // Word address
        logic [3:0]              be;     // Byte lane enables
        logic [`MEM_XLEN-1:0]    wdata;
    } dmem_req_t;

    // Kept across the RAM latency for load extension
    typedef struct packed {
        mem_op_e    mem_op;
        logic [1:0] byte_off;
    } load_ctx_t;

    typedef struct packed {
        logic                 valid;
        logic                 reg_we;
        logic [4:0]           rd;
        logic [`MEM_XLEN-1:0] result;
    } mem_wb_t;

endpackage

// File: hdl/mem_stage_config.svh
`ifndef MEM_STAGE_CONFIG_SVH
`define MEM_STAGE_CONFIG_SVH

// ******************************
// Memory stage sizing
// ******************************

// Data word width
`define MEM_XLEN 32

// Word address width of the data memory
`define MEM_DMEM_AW 10

// Words in the data memory, 1024 for AW = 10
`define MEM_DMEM_DEPTH (1 << `MEM_DMEM_AW)

`endif
